//--- bench/dlpc_stim.txt
// kind (0 write, 1 read), register address, write data or the four read bytes
// read bytes are returned most significant byte first
0 0B 00000001
1 0B E5A3017C
0 0C 00000004
0 29 12345678
1 29 FF00AA55
1 0C 80000001
0 0D 0000002B
1 0D 7E1C93D0
0 35 DEADBEEF
1 35 0102F304
1 36 C3A55A3C
0 36 00008000
1 2F 96E1077B
0 2F FFFFFFFF
1 13 4B8D20E6
0 13 00000000

//--- bench/tb_dlpc_cfg.sv
////////////////////////////////////////
// DLPC300 config bridge testbench
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_dlpc_cfg;

    localparam logic [6:0]  DEV_ADDR     = 7'h1B;
    localparam logic [15:0] CLK_PRESCALE = 16'h0127;  // Nonzero high byte
    localparam int          MAX_REQ      = 32;

    logic                    clk         = 1'b0;
    logic                    rst_n       = 1'b0;
    dlpc_cfg_pkg::dlpc_req_t req_i       = '0;
    logic                    req_valid_i = 1'b0;
    logic                    req_ready_o;
    logic [31:0]             rsp_data_o;
    logic                    rsp_valid_o;
    logic                    rsp_ready_i = 1'b0;
    dlpc_cfg_pkg::wb_m_t     wb_o;
    logic [7:0]              wb_dat_i    = 8'h00;
    logic                    wb_ack_i    = 1'b0;

    integer seed = 32'h786009d1;

    // Three stimulus words per request
    logic [31:0]             stim_mem [0:3*MAX_REQ-1];
    dlpc_cfg_pkg::dlpc_req_t req_list[$];
    int                      gap_list[$];

    // Expected traffic
    dlpc_cfg_pkg::wb_m_t     exp_wr[$];
    logic [7:0]              rx_bytes[$];
    logic [31:0]             exp_rsp[$];

    // Core model state
    int          ack_wait     = -1;   // Cycles left before ack or -1 with no access
    int          tip_left     = 0;
    logic        poll_pending = 1'b0; // CR written and tip not yet seen clear
    logic        rx_due       = 1'b0;
    logic        rsp_held     = 1'b0;
    logic [31:0] held_word    = '0;
    logic [7:0]  rd_byte;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;
    int          n_req        = 0;

    dlpc_cfg_top #(
        .SLAVE_ADDR (DEV_ADDR),
        .PRESCALE   (CLK_PRESCALE)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .rsp_data_o  (rsp_data_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .wb_o        (wb_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i)
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Checks and reporting
    ////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic string wb_text(input dlpc_cfg_pkg::wb_m_t w);
        return $sformatf("adr %0d dat %h we %b", w.adr, w.dat, w.we);
    endfunction

    task automatic check_wb_write(input dlpc_cfg_pkg::wb_m_t exp_w,
                                  input dlpc_cfg_pkg::wb_m_t act_w, input string name);
        if (act_w !== exp_w)
            report_error($sformatf("Fail at time %0t: %s expected %s, got %s",
                                   $time, name, wb_text(exp_w), wb_text(act_w)));
    endtask

    task automatic check_rsp(input logic [31:0] exp_word, input logic [31:0] act_word,
                             input string name);
        if (act_word !== exp_word)
            report_error($sformatf("Fail at time %0t: %s expected %h, got %h",
                                   $time, name, exp_word, act_word));
    endtask

    ////////////////////////////////////////
    // Expected trace from the step tables
    ////////////////////////////////////////

    function automatic logic [7:0] cmd_byte(input logic sta, input logic sto, input logic rd,
                                            input logic wr, input logic nack);
        dlpc_cfg_pkg::i2c_ctrl_u c;
        c         = '0;
        c.cmd.sta = sta;
        c.cmd.sto = sto;
        c.cmd.rd  = rd;
        c.cmd.wr  = wr;
        c.cmd.ack = nack;
        return c;
    endfunction

    task automatic push_write(input logic [2:0] adr, input logic [7:0] dat);
        dlpc_cfg_pkg::wb_m_t w;
        w.adr = adr;
        w.dat = dat;
        w.we  = 1'b1;
        w.stb = 1'b1;
        exp_wr.push_back(w);
    endtask

    task automatic add_expected(input dlpc_cfg_pkg::dlpc_req_t r, input logic [31:0] rbytes);
        int k;
        push_write(dlpc_cfg_pkg::WB_TXR_RXR, {DEV_ADDR, 1'b0});
        push_write(dlpc_cfg_pkg::WB_CR_SR, cmd_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
        push_write(dlpc_cfg_pkg::WB_TXR_RXR, r.reg_addr);
        push_write(dlpc_cfg_pkg::WB_CR_SR, cmd_byte(1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
        if (r.is_read)
        begin
            push_write(dlpc_cfg_pkg::WB_TXR_RXR, {DEV_ADDR, 1'b1});  // Repeated start
            push_write(dlpc_cfg_pkg::WB_CR_SR, cmd_byte(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
            repeat (3)
                push_write(dlpc_cfg_pkg::WB_CR_SR, cmd_byte(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
            push_write(dlpc_cfg_pkg::WB_CR_SR, cmd_byte(1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
            for (k = 3; k >= 0; k--)
                rx_bytes.push_back(rbytes[8*k +: 8]);
            exp_rsp.push_back(rbytes);  // First byte returned lands in the MSBs
        end
        else
        begin
            for (k = 3; k >= 0; k--)
            begin
                push_write(dlpc_cfg_pkg::WB_TXR_RXR, r.wdata[8*k +: 8]);
                push_write(dlpc_cfg_pkg::WB_CR_SR, cmd_byte(1'b0, k == 0, 1'b0, 1'b1, 1'b0));
            end
        end
    endtask

    ////////////////////////////////////////
    // I2C master core register model
    ////////////////////////////////////////

    task automatic serve_write(input dlpc_cfg_pkg::wb_m_t w);
        dlpc_cfg_pkg::i2c_ctrl_u c;
        if (poll_pending && (w.adr == dlpc_cfg_pkg::WB_TXR_RXR || w.adr == dlpc_cfg_pkg::WB_CR_SR))
            report_error("TXR or CR written before a status read returned tip clear");
        if (exp_wr.size() == 0)
            report_error("Wishbone write seen after all expected writes were done");
        check_wb_write(exp_wr.pop_front(), w, "wb_o");
        if (w.adr == dlpc_cfg_pkg::WB_CR_SR)
        begin
            c            = w.dat;
            poll_pending = 1'b1;
            rx_due       = c.cmd.rd;
            tip_left     = {$random(seed)} % 4;  // Polls that still see tip set
        end
    endtask

    task automatic serve_read(input dlpc_cfg_pkg::wb_m_t w, output logic [7:0] dat);
        dlpc_cfg_pkg::i2c_ctrl_u sr;
        sr  = '0;
        dat = 8'h00;
        if (w.adr == dlpc_cfg_pkg::WB_CR_SR)
        begin
            if (!poll_pending)
                report_error("Status register read with no command in progress");
            if (tip_left > 0)
            begin
                sr.stat.busy = 1'b1;
                sr.stat.tip  = 1'b1;
                tip_left     = tip_left - 1;
            end
            else
                poll_pending = 1'b0;
            dat = sr;
        end
        else if (w.adr == dlpc_cfg_pkg::WB_TXR_RXR)
        begin
            if (poll_pending || !rx_due || rx_bytes.size() == 0)
                report_error("Receive register read with no finished receive command");
            rx_due = 1'b0;
            dat    = rx_bytes.pop_front();
        end
        else
            report_error("Wishbone read of a core register that is never read back");
    endtask

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
            report_error($sformatf("Timeout after %0d cycles with traffic still pending",
                                   cycle_cnt));
        if (rst_n)
        begin
            if (wb_ack_i)
                wb_ack_i <= 1'b0;  // Single cycle ack
            else if (wb_o.stb)
            begin
                if (ack_wait < 0)
                    ack_wait = {$random(seed)} % 3;
                if (ack_wait == 0)
                begin
                    ack_wait = -1;
                    if (wb_o.we)
                        serve_write(wb_o);
                    else
                    begin
                        serve_read(wb_o, rd_byte);
                        wb_dat_i <= rd_byte;
                    end
                    wb_ack_i <= 1'b1;
                end
                else
                    ack_wait = ack_wait - 1;
            end

            // Held response word must not move
            if (rsp_valid_o)
            begin
                if (rsp_held)
                    check_rsp(held_word, rsp_data_o, "rsp_data_o (held)");
                if (rsp_ready_i)
                begin
                    if (exp_rsp.size() == 0)
                        report_error("Read response with no read request outstanding");
                    check_rsp(exp_rsp.pop_front(), rsp_data_o, "rsp_data_o");
                    rsp_held = 1'b0;
                end
                else
                begin
                    rsp_held  = 1'b1;
                    held_word = rsp_data_o;
                end
            end
            rsp_ready_i <= ({$random(seed)} % 4) != 0;
        end
    end

    ////////////////////////////////////////
    // Stimulus and end of run
    ////////////////////////////////////////

    initial
    begin
        dlpc_cfg_pkg::dlpc_req_t r;
        for (int i = 0; i < 3 * MAX_REQ; i++)
            stim_mem[i] = 32'hFFFF_0000 | i;  // End marker
        $readmemh("bench/dlpc_stim.txt", stim_mem);

        // Core setup comes first
        push_write(dlpc_cfg_pkg::WB_PRER_LO, CLK_PRESCALE[7:0]);
        push_write(dlpc_cfg_pkg::WB_PRER_HI, CLK_PRESCALE[15:8]);
        push_write(dlpc_cfg_pkg::WB_CTR, dlpc_cfg_pkg::CTR_CORE_EN);

        while (n_req < MAX_REQ && stim_mem[3 * n_req] <= 32'd1)
        begin
            r.is_read  = stim_mem[3 * n_req][0];
            r.reg_addr = stim_mem[3 * n_req + 1][7:0];
            r.wdata    = r.is_read ? 32'h0 : stim_mem[3 * n_req + 2];
            req_list.push_back(r);
            gap_list.push_back({$random(seed)} % 4);
            add_expected(r, stim_mem[3 * n_req + 2]);
            n_req++;
        end
        cycle_limit = 200 * n_req + 100;
        if (n_req == 0)
            report_error("No requests found in bench/dlpc_stim.txt");

        repeat (2) @(posedge clk);
        if (req_ready_o || wb_o.stb || rsp_valid_o)
            report_error("Control outputs active while reset is held");
        rst_n <= 1'b1;

        for (int i = 0; i < n_req; i++)
        begin
            repeat (gap_list[i])
            begin
                req_valid_i <= 1'b0;
                @(posedge clk);
            end
            req_i       <= req_list[i];
            req_valid_i <= 1'b1;
            do
                @(posedge clk);
            while (!req_ready_o);
        end
        req_valid_i <= 1'b0;

        while (exp_wr.size() != 0 || exp_rsp.size() != 0)
            @(posedge clk);
        repeat (50) @(posedge clk);  // Trailing polls and any stray access

        if (poll_pending || rx_due || rsp_held || rx_bytes.size() != 0)
            report_error("A transfer was still open at the end of the run");
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hw/dlpc_byte_sequencer.sv
////////////////////////////////////////
// I2C byte step sequencer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dlpc_byte_sequencer #(
    parameter logic [6:0] SLAVE_ADDR = 7'h1B
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  dlpc_cfg_pkg::dlpc_req_t req_i,
    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    output dlpc_cfg_pkg::i2c_step_t step_o,
    output logic                    step_valid_o,
    input  wire                     step_ready_i
);

    dlpc_cfg_pkg::dlpc_req_t cur_q;  // Request being expanded
    logic                    busy_q;
    logic [2:0]              idx_q;  // Step index within the request

    logic       step_fire;
    logic [2:0] last_idx;

    assign step_fire = busy_q && step_ready_i;
    assign last_idx  = cur_q.is_read ? 3'd6 : 3'd5;

    ////////////////////////////////////////
    // Request hold and step counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q <= 1'b0;
            idx_q  <= 3'd0;
        end
        else if (!busy_q)
        begin
            if (req_valid_i)
            begin
                busy_q <= 1'b1;
                idx_q  <= 3'd0;
            end
        end
        else if (step_fire)
        begin
            if (idx_q == last_idx)
                busy_q <= 1'b0;  // Free for the next request
            else
                idx_q <= idx_q + 3'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy_q && req_valid_i)
            cur_q <= req_i;
    end

    ////////////////////////////////////////
    // Step table
    ////////////////////////////////////////

    always_comb
    begin
        step_o = '0;
        case (idx_q)
            3'd0:
            begin
                step_o.ctrl.cmd.sta = 1'b1;
                step_o.ctrl.cmd.wr  = 1'b1;
                step_o.tx_byte      = {SLAVE_ADDR, 1'b0};  // Write bit
            end
            3'd1:
            begin
                step_o.ctrl.cmd.wr = 1'b1;
                step_o.tx_byte     = cur_q.reg_addr;
            end
            3'd2:
            begin
                step_o.ctrl.cmd.wr = 1'b1;
                if (cur_q.is_read)
                begin
                    step_o.ctrl.cmd.sta = 1'b1;  // Repeated start
                    step_o.tx_byte      = {SLAVE_ADDR, 1'b1};
                end
                else
                    step_o.tx_byte = cur_q.wdata[31:24];
            end
            3'd3, 3'd4, 3'd5:
            begin
                if (cur_q.is_read)
                    step_o.ctrl.cmd.rd = 1'b1;
                else
                begin
                    step_o.ctrl.cmd.wr  = 1'b1;
                    step_o.ctrl.cmd.sto = (idx_q == 3'd5);  // Last write byte
                    case (idx_q)
                        3'd3:    step_o.tx_byte = cur_q.wdata[23:16];
                        3'd4:    step_o.tx_byte = cur_q.wdata[15:8];
                        default: step_o.tx_byte = cur_q.wdata[7:0];
                    endcase
                end
            end
            default:
            begin
                // Final read byte with NACK and stop
                step_o.ctrl.cmd.rd  = 1'b1;
                step_o.ctrl.cmd.ack = 1'b1;
                step_o.ctrl.cmd.sto = 1'b1;
                step_o.last         = 1'b1;
            end
        endcase
    end

    assign step_valid_o = busy_q;
    assign req_ready_o  = !busy_q;

endmodule

`default_nettype wire

//--- hw/dlpc_cfg_pkg.sv
////////////////////////////////////////
// DLPC300 config bridge shared types
////////////////////////////////////////
`default_nettype none

package dlpc_cfg_pkg;

    // Byte-level I2C master core register map
    localparam logic [2:0] WB_PRER_LO = 3'd0;
    localparam logic [2:0] WB_PRER_HI = 3'd1;
    localparam logic [2:0] WB_CTR     = 3'd2;
    localparam logic [2:0] WB_TXR_RXR = 3'd3;  // TXR on write, RXR on read
    localparam logic [2:0] WB_CR_SR   = 3'd4;  // CR on write, SR on read

    localparam logic [7:0] CTR_CORE_EN = 8'h80;  // Core enable, interrupt off

    // Command register layout
    typedef struct packed {
        logic       sta;
        logic       sto;
        logic       rd;
        logic       wr;
        logic       ack;   // Set means NACK on receive
        logic [1:0] rsvd;
        logic       iack;
    } i2c_cmd_t;

    // Status register layout
    typedef struct packed {
        logic       rxack;
        logic       busy;
        logic       al;
        logic [2:0] rsvd;
        logic       tip;   // Transfer in progress
        logic       iflag;
    } i2c_stat_t;

    // Register 4 byte, written as command and read back as status
    typedef union packed {
        i2c_cmd_t  cmd;
        i2c_stat_t stat;
    } i2c_ctrl_u;

    typedef struct packed {
        logic        is_read;
        logic [7:0]  reg_addr;
        logic [31:0] wdata;
    } dlpc_req_t;

    typedef struct packed {
        i2c_ctrl_u  ctrl;
        logic [7:0] tx_byte;  // Unused on receive steps
        logic       last;
    } i2c_step_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } rx_byte_t;

    typedef struct packed {
        logic [2:0] adr;
        logic [7:0] dat;
        logic       we;
        logic       stb;   // Also drives cyc
    } wb_m_t;

endpackage

`default_nettype wire

//--- hw/dlpc_cfg_top.sv
////////////////////////////////////////
// DLPC300 configuration bridge top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dlpc_cfg_top #(
    parameter logic [6:0]  SLAVE_ADDR = 7'h1B,
    parameter logic [15:0] PRESCALE   = 16'h0031
) (
    input  wire                     clk,
    input  wire                     rst_n,
    // Host side
    input  dlpc_cfg_pkg::dlpc_req_t req_i,
    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    output logic [31:0]             rsp_data_o,
    output logic                    rsp_valid_o,
    input  wire                     rsp_ready_i,
    // I2C master core register port
    output dlpc_cfg_pkg::wb_m_t     wb_o,
    input  wire [7:0]               wb_dat_i,
    input  wire                     wb_ack_i
);

    dlpc_cfg_pkg::dlpc_req_t req_q;
    logic                    req_q_valid;
    logic                    req_q_ready;

    dlpc_cfg_pkg::i2c_step_t step;
    logic                    step_valid;
    logic                    step_ready;

    dlpc_cfg_pkg::rx_byte_t  rx_byte;
    logic                    rx_valid;
    logic                    rx_ready;

    dlpc_req_stage u_req (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_o       (req_q),
        .req_valid_o (req_q_valid),
        .req_ready_i (req_q_ready)
    );

    dlpc_byte_sequencer #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req_q),
        .req_valid_i  (req_q_valid),
        .req_ready_o  (req_q_ready),
        .step_o       (step),
        .step_valid_o (step_valid),
        .step_ready_i (step_ready)
    );

    dlpc_wb_stage #(
        .PRESCALE (PRESCALE)
    ) u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .step_i       (step),
        .step_valid_i (step_valid),
        .step_ready_o (step_ready),
        .wb_o         (wb_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .rx_o         (rx_byte),
        .rx_valid_o   (rx_valid),
        .rx_ready_i   (rx_ready)
    );

    dlpc_rsp_stage u_rsp (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_i        (rx_byte),
        .rx_valid_i  (rx_valid),
        .rx_ready_o  (rx_ready),
        .rsp_data_o  (rsp_data_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_valid_o (rsp_valid_o)
    );

endmodule

`default_nettype wire

//--- hw/dlpc_req_stage.sv
////////////////////////////////////////
// Host request skid buffer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dlpc_req_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  dlpc_cfg_pkg::dlpc_req_t req_i,
    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    output dlpc_cfg_pkg::dlpc_req_t req_o,
    output logic                    req_valid_o,
    input  wire                     req_ready_i
);

    dlpc_cfg_pkg::dlpc_req_t out_q;
    dlpc_cfg_pkg::dlpc_req_t skid_q;
    logic                    out_valid_q;
    logic                    skid_valid_q;
    logic                    ready_q;

    logic in_fire;
    logic out_free;

    assign in_fire  = req_valid_i && ready_q;
    assign out_free = !out_valid_q || req_ready_i;  // Output slot empties this cycle

    // Control flags
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            ready_q      <= 1'b0;
        end
        else
        begin
            if (out_free)
            begin
                out_valid_q  <= skid_valid_q || in_fire;
                skid_valid_q <= 1'b0;
                ready_q      <= 1'b1;
            end
            else if (in_fire)
            begin
                skid_valid_q <= 1'b1;  // Park behind the stalled entry
                ready_q      <= 1'b0;
            end
            else
            begin
                ready_q <= !skid_valid_q;
            end
        end
    end

    // Payload
    always_ff @(posedge clk)
    begin
        if (out_free)
            out_q <= skid_valid_q ? skid_q : req_i;
        else if (in_fire)
            skid_q <= req_i;
    end

    assign req_ready_o = ready_q;
    assign req_o       = out_q;
    assign req_valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- hw/dlpc_rsp_stage.sv
////////////////////////////////////////
// Read word assembly
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dlpc_rsp_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  dlpc_cfg_pkg::rx_byte_t rx_i,
    input  wire                    rx_valid_i,
    output logic                   rx_ready_o,
    output logic [31:0]            rsp_data_o,
    input  wire                    rsp_ready_i,
    output logic                   rsp_valid_o
);

    logic [31:0] shift_q;
    logic [31:0] word_q;    // Word presented to the host
    logic        rsp_valid_q;
    logic        rx_fire;

    assign rx_ready_o = !rsp_valid_q;  // Stall the pipe while a word waits
    assign rx_fire    = rx_valid_i && rx_ready_o;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rsp_valid_q <= 1'b0;
        else if (rx_fire && rx_i.last)
            rsp_valid_q <= 1'b1;
        else if (rsp_ready_i)
            rsp_valid_q <= 1'b0;
    end

    // MSB first shift with the final byte completing the word
    always_ff @(posedge clk)
    begin
        if (rx_fire)
        begin
            shift_q <= {shift_q[23:0], rx_i.data};
            if (rx_i.last)
                word_q <= {shift_q[23:0], rx_i.data};
        end
    end

    assign rsp_data_o  = word_q;
    assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

//--- hw/dlpc_wb_stage.sv
////////////////////////////////////////
// Wishbone access sequencer for the
// I2C master core
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dlpc_wb_stage #(
    parameter logic [15:0] PRESCALE = 16'h0031
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  dlpc_cfg_pkg::i2c_step_t step_i,
    input  wire                     step_valid_i,
    output logic                    step_ready_o,
    output dlpc_cfg_pkg::wb_m_t     wb_o,
    input  wire [7:0]               wb_dat_i,
    input  wire                     wb_ack_i,
    output dlpc_cfg_pkg::rx_byte_t  rx_o,
    output logic                    rx_valid_o,
    input  wire                     rx_ready_i
);

    typedef enum logic [2:0] {
        ST_INIT, ST_IDLE, ST_TXR, ST_CMD, ST_POLL, ST_RXR, ST_HAND
    } state_t;

    state_t                  state_q;
    logic [1:0]              init_cnt_q;
    dlpc_cfg_pkg::wb_m_t     wb_q;
    dlpc_cfg_pkg::wb_m_t     acc;       // Access wanted by the current phase
    dlpc_cfg_pkg::i2c_step_t step_q;
    dlpc_cfg_pkg::rx_byte_t  rx_q;
    dlpc_cfg_pkg::i2c_ctrl_u sr_byte;
    logic                    rx_valid_q;
    logic                    acc_done;

    assign acc_done = wb_q.stb && wb_ack_i;
    assign sr_byte  = wb_dat_i;  // Status view of register 4

    ////////////////////////////////////////
    // Access selection per phase
    ////////////////////////////////////////

    always_comb
    begin
        acc     = '0;
        acc.stb = 1'b1;
        case (state_q)
            ST_INIT:
            begin
                acc.we = 1'b1;
                case (init_cnt_q)
                    2'd0:
                    begin
                        acc.adr = dlpc_cfg_pkg::WB_PRER_LO;
                        acc.dat = PRESCALE[7:0];
                    end
                    2'd1:
                    begin
                        acc.adr = dlpc_cfg_pkg::WB_PRER_HI;
                        acc.dat = PRESCALE[15:8];
                    end
                    default:
                    begin
                        acc.adr = dlpc_cfg_pkg::WB_CTR;
                        acc.dat = dlpc_cfg_pkg::CTR_CORE_EN;
                    end
                endcase
            end
            ST_TXR:
            begin
                acc.adr = dlpc_cfg_pkg::WB_TXR_RXR;
                acc.dat = step_q.tx_byte;
                acc.we  = 1'b1;
            end
            ST_CMD:
            begin
                acc.adr = dlpc_cfg_pkg::WB_CR_SR;
                acc.dat = step_q.ctrl;
                acc.we  = 1'b1;
            end
            ST_POLL: acc.adr = dlpc_cfg_pkg::WB_CR_SR;
            ST_RXR:  acc.adr = dlpc_cfg_pkg::WB_TXR_RXR;
            default: acc.stb = 1'b0;  // Idle and hand-off need no bus
        endcase
    end

    ////////////////////////////////////////
    // Phase FSM and bus strobe
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q    <= ST_INIT;
            init_cnt_q <= 2'd0;
            wb_q       <= '0;
            rx_valid_q <= 1'b0;
        end
        else
        begin
            if (!wb_q.stb && acc.stb)
                wb_q <= acc;          // Start access after a low cycle
            else if (acc_done)
                wb_q.stb <= 1'b0;

            case (state_q)
                ST_INIT:
                    if (acc_done)
                    begin
                        if (init_cnt_q == 2'd2)
                            state_q <= ST_IDLE;
                        init_cnt_q <= init_cnt_q + 2'd1;
                    end
                ST_IDLE:
                    if (step_valid_i)
                        state_q <= step_i.ctrl.cmd.wr ? ST_TXR : ST_CMD;
                ST_TXR:
                    if (acc_done)
                        state_q <= ST_CMD;
                ST_CMD:
                    if (acc_done)
                        state_q <= ST_POLL;
                ST_POLL:
                    if (acc_done && !sr_byte.stat.tip)
                        state_q <= step_q.ctrl.cmd.rd ? ST_RXR : ST_IDLE;
                ST_RXR:
                    if (acc_done)
                    begin
                        rx_valid_q <= 1'b1;
                        state_q    <= ST_HAND;
                    end
                default:
                    if (rx_ready_i)
                    begin
                        rx_valid_q <= 1'b0;
                        state_q    <= ST_IDLE;
                    end
            endcase
        end
    end

    // Step and received byte payload
    always_ff @(posedge clk)
    begin
        if (state_q == ST_IDLE && step_valid_i)
            step_q <= step_i;
        if (state_q == ST_RXR && acc_done)
            rx_q <= '{data: wb_dat_i, last: step_q.last};
    end

    assign step_ready_o = (state_q == ST_IDLE);
    assign wb_o         = wb_q;
    assign rx_o         = rx_q;
    assign rx_valid_o   = rx_valid_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the DLPC300 config bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_dlpc_cfg -f sim.f

out=$(./obj_dir/Vtb_dlpc_cfg 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi

//--- sim.f
hw/dlpc_cfg_pkg.sv
hw/dlpc_req_stage.sv
hw/dlpc_byte_sequencer.sv
hw/dlpc_wb_stage.sv
hw/dlpc_rsp_stage.sv
hw/dlpc_cfg_top.sv
bench/tb_dlpc_cfg.sv
